//--- audio_lpf_top.f
hw/audio_pkg.sv
hw/filt_pkg.sv
hw/stereo_acc_if.sv
hw/lpf_bank.sv
hw/filter_ctrl.sv
hw/output_limiter.sv
hw/audio_lpf_top.sv
test/tb_audio_lpf_top.sv

//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module audio_lpf_top -f audio_lpf_top.f

sim:
	verilator --binary --timing --top-module tb_audio_lpf_top -f audio_lpf_top.f -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "^Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/lpf_golden.txt
# Columns: cmd left right exp_left exp_right exp_left_clip exp_right_clip
# cmd 0 idle, 1 sample, 2 write mode=left, 3 left random fills, 4 fill with left/right, 9 end
1 1000 2000 500 1000 0 0
0 0 0 0 0 0 0
1 -3 5 498 1002 0 0
9 0 0 0 0 0 0
2 1 0 0 0 0 0
4 0 0 0 0 0 0
1 1001 -1001 250 -251 0 0
1 1001 -1001 500 -502 0 0
1 1001 -1001 750 -753 0 0
1 1001 -1001 1000 -1004 0 0
2 2 0 0 0 0 0
4 0 0 0 0 0 0
1 800 -800 100 -100 0 0
1 0 0 100 -100 0 0
2 3 0 0 0 0 0
4 0 0 0 0 0 0
1 1600 -17 100 -2 0 0
1 0 0 100 -2 0 0
9 0 0 0 0 0 0
2 4 0 0 0 0 0
4 0 0 0 0 0 0
1 4096 -8192 64 -128 0 0
1 0 0 64 -128 0 0
1 0 0 128 -256 0 0
1 0 0 256 -512 0 0
1 0 0 512 -1024 0 0
1 0 0 1024 -2048 0 0
2 5 0 0 0 0 0
4 0 0 0 0 0 0
1 65536 -65536 256 -256 0 0
1 0 0 256 -256 0 0
1 0 0 512 -512 0 0
1 0 0 1024 -1024 0 0
2 6 0 0 0 0 0
4 0 0 0 0 0 0
1 65536 -1000 32 -1 0 0
1 0 0 32 -1 0 0
1 0 0 64 -1 0 0
9 0 0 0 0 0 0
2 7 0 0 0 0 0
4 8388607 -8388608 0 0 0 0
1 8388607 -8388608 8388591 -8388608 0 0
9 0 0 0 0 0 0
2 0 0 0 0 0 0
3 10 0 0 0 0 0
2 0 0 0 0 0 0
4 300 -300 0 0 0 0
1 300 -300 300 -300 0 0
9 0 0 0 0 0 0
1 1000 -3000 650 -1650 0 0
1 0 5 500 -1498 0 0
1 -7 7 -4 5 0 0
9 0 0 0 0 0 0

//--- test/tb_audio_lpf_top.sv
`default_nettype none

module tb_audio_lpf_top
	import audio_pkg::*;
	import filt_pkg::*;
();

	localparam int cycles_per_line = 20;

	// One golden line. For a sample the last four fields are the expected outputs.
	typedef struct packed {
		int cmd;
		int l;
		int r;
		int el;
		int er;
		int ecl;
		int ecr;
	} vec_t;

	logic                           clk;
	logic                           reset_n;
	logic                           sample_en;
	logic signed [sample_width-1:0] left_in;
	logic signed [sample_width-1:0] right_in;
	logic                           filt_wr;
	filt_mode_e                     filt_sel;
	logic                           out_valid;
	logic signed [sample_width-1:0] left_out;
	logic signed [sample_width-1:0] right_out;
	logic                           left_clip;
	logic                           right_clip;

	vec_t   vecs[$];
	vec_t   exp_q[$];
	int     strobe_q[$];
	int     cycle = 0;
	int     checks = 0;
	int     errors = 0;
	int     test_num = 0;
	int     checks_mark = 0;
	int     errors_mark = 0;
	integer seed;
	bit     vectors_loaded = 1'b0;

	audio_lpf_top #(.BIT_WIDTH(sample_width)) u_audio_lpf_top (
		.clk        (clk),
		.reset_n    (reset_n),
		.sample_en  (sample_en),
		.left_in    (left_in),
		.right_in   (right_in),
		.filt_wr    (filt_wr),
		.filt_sel   (filt_sel),
		.out_valid  (out_valid),
		.left_out   (left_out),
		.right_out  (right_out),
		.left_clip  (left_clip),
		.right_clip (right_clip)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic compare(input string what, input int actual, input int expected);
		checks++;
		if (actual != expected) begin
			$display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			errors++;
		end
	endtask

	// All inputs change together on the rising edge.
	task automatic drive_cycle(input logic strobe, input int l, input int r,
			input logic wr, input int sel);
		@(posedge clk);
		sample_en <= strobe;
		left_in   <= sample_width'(l);
		right_in  <= sample_width'(r);
		filt_wr   <= wr;
		filt_sel  <= filt_mode_e'(sel);
	endtask

	task automatic load_vectors();
		int    fd;
		int    n;
		string line;
		vec_t  v;
		fd = $fopen("test/lpf_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/lpf_golden.txt for reading");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %d %d %d %d %d",
					v.cmd, v.l, v.r, v.el, v.er, v.ecl, v.ecr);
				if (n == 7) begin
					vecs.push_back(v);
				end else begin
					$display("Malformed line in the golden file: %s", line);
					errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	// Waits until every sample in flight has been checked.
	task automatic finish_test();
		drive_cycle(1'b0, 0, 0, 1'b0, 0);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		test_num++;
		$display("test %0d done: %0d checks, %0d errors", test_num,
			checks - checks_mark, errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	task automatic run_line(input vec_t v);
		case (v.cmd)
			0: drive_cycle(1'b0, 0, 0, 1'b0, 0);
			1: begin
				drive_cycle(1'b1, v.l, v.r, 1'b0, 0);
				exp_q.push_back(v);
			end
			2: drive_cycle(1'b0, 0, 0, 1'b1, v.l);
			// Fill strobes fall inside the mute window, so the output is silent.
			3: repeat (v.l) begin
				drive_cycle(1'b1, $random(seed), $random(seed), 1'b0, 0);
				exp_q.push_back('0);
			end
			4: repeat (mute_samples) begin
				drive_cycle(1'b1, v.l, v.r, 1'b0, 0);
				exp_q.push_back('0);
			end
			9: finish_test();
			default: begin
				$display("Unknown command %0d in the golden file", v.cmd);
				errors++;
			end
		endcase
	endtask

	// Outputs are sampled on the falling edge, well away from the driving edge.
	always @(negedge clk) begin
		vec_t want;
		int   t0;
		if (reset_n && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("error at %0t: out_valid with no sample outstanding", $time);
				errors++;
			end else begin
				want = exp_q.pop_front();
				t0   = strobe_q.pop_front();
				compare("latency in cycles", cycle - t0, 2);
				compare("left_out", int'(left_out), want.el);
				compare("right_out", int'(right_out), want.er);
				compare("left_clip", int'(left_clip), want.ecl);
				compare("right_clip", int'(right_clip), want.ecr);
			end
		end
		if (reset_n && sample_en) begin
			strobe_q.push_back(cycle);
		end
	end

	initial begin
		wait (vectors_loaded);
		repeat ((vecs.size() + 5) * cycles_per_line) @(posedge clk);
		$display("Timeout: the outputs did not arrive within the expected run time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		reset_n   = 1'b0;
		sample_en = 1'b0;
		left_in   = '0;
		right_in  = '0;
		filt_wr   = 1'b0;
		filt_sel  = avg2;
		seed      = 85;
		load_vectors();
		vectors_loaded = 1'b1;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		compare("out_valid after reset", int'(out_valid), 0);
		compare("left_out after reset", int'(left_out), 0);
		compare("right_out after reset", int'(right_out), 0);
		compare("left_clip after reset", int'(left_clip), 0);
		compare("right_clip after reset", int'(right_clip), 0);
		foreach (vecs[i]) begin
			run_line(vecs[i]);
		end
		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/audio_lpf_top.sv
`default_nettype none

// Stereo low-pass filter with selectable power-of-two coefficient sets.
// Output samples appear two cycles after each sample strobe.
module audio_lpf_top
	import audio_pkg::*;
	import filt_pkg::*;
#(
	parameter int BIT_WIDTH = sample_width
) (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        sample_en,
	input  logic signed [BIT_WIDTH-1:0] left_in,
	input  logic signed [BIT_WIDTH-1:0] right_in,
	input  logic                        filt_wr,
	input  filt_mode_e                  filt_sel,
	output logic                        out_valid,
	output logic signed [BIT_WIDTH-1:0] left_out,
	output logic signed [BIT_WIDTH-1:0] right_out,
	output logic                        left_clip,
	output logic                        right_clip
);

	filt_mode_e mode;

	stereo_acc_if #(.BIT_WIDTH(BIT_WIDTH)) acc_bus ();

	filter_ctrl u_filter_ctrl (
		.clk       (clk),
		.reset_n   (reset_n),
		.filt_wr   (filt_wr),
		.filt_sel  (filt_sel),
		.sample_en (sample_en),
		.mode      (mode),
		.mute      (acc_bus.mute)
	);

	lpf_bank #(.BIT_WIDTH(BIT_WIDTH)) u_left_lpf (
		.clk       (clk),
		.reset_n   (reset_n),
		.sample_en (sample_en),
		.sample_in (left_in),
		.mode      (mode),
		.acc       (acc_bus.left_acc),
		.acc_valid (acc_bus.acc_valid)
	);

	// Same strobe and mode as the left bank, so its valid is identical.
	lpf_bank #(.BIT_WIDTH(BIT_WIDTH)) u_right_lpf (
		.clk       (clk),
		.reset_n   (reset_n),
		.sample_en (sample_en),
		.sample_in (right_in),
		.mode      (mode),
		.acc       (acc_bus.right_acc),
		.acc_valid ()
	);

	output_limiter #(.BIT_WIDTH(BIT_WIDTH)) u_output_limiter (
		.clk        (clk),
		.reset_n    (reset_n),
		.acc_bus    (acc_bus.sink),
		.left_out   (left_out),
		.right_out  (right_out),
		.left_clip  (left_clip),
		.right_clip (right_clip),
		.out_valid  (out_valid)
	);

endmodule

`default_nettype wire

//--- hw/output_limiter.sv
`default_nettype none

// Final stage of both channels.
// Clamps each accumulator to the sample range and flags the clamp. While
// mute is high it forces silence with the flags clear.
module output_limiter
	import audio_pkg::*;
#(
	parameter int BIT_WIDTH = sample_width
) (
	input  logic                        clk,
	input  logic                        reset_n,
	stereo_acc_if.sink                  acc_bus,
	output logic signed [BIT_WIDTH-1:0] left_out,
	output logic signed [BIT_WIDTH-1:0] right_out,
	output logic                        left_clip,
	output logic                        right_clip,
	output logic                        out_valid
);

	localparam int ACC_W = BIT_WIDTH + guard_bits;

	// Full-scale limits, sign-extended to accumulator width.
	localparam logic signed [ACC_W-1:0] SAT_MAX =
		{{(guard_bits + 1){1'b0}}, {(BIT_WIDTH - 1){1'b1}}};
	localparam logic signed [ACC_W-1:0] SAT_MIN =
		{{(guard_bits + 1){1'b1}}, {(BIT_WIDTH - 1){1'b0}}};

	logic [BIT_WIDTH:0] left_sat;
	logic [BIT_WIDTH:0] right_sat;

	// Result is {clip, sample}.
	function automatic logic [BIT_WIDTH:0] saturate(input logic signed [ACC_W-1:0] a);
		if (a > SAT_MAX) begin
			return {1'b1, SAT_MAX[BIT_WIDTH-1:0]};
		end else if (a < SAT_MIN) begin
			return {1'b1, SAT_MIN[BIT_WIDTH-1:0]};
		end
		return {1'b0, a[BIT_WIDTH-1:0]};
	endfunction

	assign left_sat  = saturate(acc_bus.left_acc);
	assign right_sat = saturate(acc_bus.right_acc);

	// Outputs hold between strobes.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			left_out   <= '0;
			right_out  <= '0;
			left_clip  <= 1'b0;
			right_clip <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			out_valid <= acc_bus.acc_valid;
			if (acc_bus.acc_valid) begin
				if (acc_bus.mute) begin
					left_out   <= '0;
					right_out  <= '0;
					left_clip  <= 1'b0;
					right_clip <= 1'b0;
				end else begin
					left_out   <= left_sat[BIT_WIDTH-1:0];
					right_out  <= right_sat[BIT_WIDTH-1:0];
					left_clip  <= left_sat[BIT_WIDTH];
					right_clip <= right_sat[BIT_WIDTH];
				end
			end
		end
	end

	// A muted sample never carries a clip flag out.
	a_no_clip_when_muted: assert property (@(posedge clk) disable iff (!reset_n)
		acc_bus.acc_valid && acc_bus.mute |=> !left_clip && !right_clip);

endmodule

`default_nettype wire

//--- hw/filter_ctrl.sv
`default_nettype none

// Holds the active filter mode and mutes the output after each selection
// write, until the delay line has been refilled under the new mode.
module filter_ctrl
	import filt_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic       filt_wr,
	input  filt_mode_e filt_sel,
	input  logic       sample_en,
	output filt_mode_e mode,
	output logic       mute
);

	localparam int CNT_W = $clog2(mute_samples + 1);

	logic [CNT_W-1:0] mute_cnt;
	logic             strobe_d;

	// The count steps on the strobe delayed by one cycle. That is the cycle in
	// which the matching accumulator reaches the limiter, so exactly
	// mute_samples outputs are muted after a write.
	// A write always reloads, even when it repeats the mode or lands
	// while the count is still running.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			mode     <= avg2;
			mute_cnt <= '0;
			strobe_d <= 1'b0;
		end else begin
			strobe_d <= sample_en;
			if (filt_wr) begin
				mode     <= filt_sel;
				mute_cnt <= CNT_W'(mute_samples);
			end else if (strobe_d && mute_cnt != '0) begin
				mute_cnt <= mute_cnt - CNT_W'(1);
			end
		end
	end

	assign mute = (mute_cnt != '0);

	a_cnt_bounded: assert property (@(posedge clk) disable iff (!reset_n)
		mute_cnt <= CNT_W'(mute_samples));

endmodule

`default_nettype wire

//--- hw/lpf_bank.sv
`default_nettype none

// One channel of the low-pass filter.
// A num_taps deep delay line advances on each sample strobe, and in the same
// edge the accumulator takes the shift-add sum over the shifted taps. Every
// coefficient is a power of two, so each term is an arithmetic right shift.
module lpf_bank
	import audio_pkg::*;
	import filt_pkg::*;
#(
	parameter int BIT_WIDTH = sample_width
) (
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  logic                                   sample_en,
	input  logic signed [BIT_WIDTH-1:0]            sample_in,
	input  filt_mode_e                             mode,
	output logic signed [BIT_WIDTH+guard_bits-1:0] acc,
	output logic                                   acc_valid
);

	localparam int ACC_W = BIT_WIDTH + guard_bits;

	logic signed [BIT_WIDTH-1:0] taps      [num_taps];
	logic signed [BIT_WIDTH-1:0] taps_next [num_taps];
	logic signed [ACC_W-1:0]     acc_next;

	// Sign-extends a tap to accumulator width and shifts it right.
	// The shift rounds towards minus infinity, which is the truncation the
	// coefficients are specified with.
	function automatic logic signed [ACC_W-1:0] tap_shr(
		input logic signed [BIT_WIDTH-1:0] x,
		input int unsigned                 sh
	);
		logic signed [ACC_W-1:0] ext;
		ext = ACC_W'(x);
		return ext >>> sh;
	endfunction

	// Delay line contents after this strobe.
	always_comb begin
		taps_next[0] = sample_in;
		for (int i = 1; i < num_taps; i++) begin
			taps_next[i] = taps[i-1];
		end
	end

	// Each term is truncated on its own before the add.
	always_comb begin
		acc_next = '0;
		case (mode)
			avg2: begin
				for (int i = 0; i < 2; i++) begin
					acc_next += tap_shr(taps_next[i], 1);
				end
			end
			avg4: begin
				for (int i = 0; i < 4; i++) begin
					acc_next += tap_shr(taps_next[i], 2);
				end
			end
			avg8: begin
				for (int i = 0; i < 8; i++) begin
					acc_next += tap_shr(taps_next[i], 3);
				end
			end
			avg16: begin
				for (int i = 0; i < 16; i++) begin
					acc_next += tap_shr(taps_next[i], 4);
				end
			end
			shape_a: begin
				acc_next = tap_shr(taps_next[0], 6) +
					tap_shr(taps_next[1], 6) +
					tap_shr(taps_next[2], 5) +
					tap_shr(taps_next[3], 4) +
					tap_shr(taps_next[4], 3) +
					tap_shr(taps_next[5], 2) +
					tap_shr(taps_next[6], 2) +
					tap_shr(taps_next[7], 2);
			end
			shape_b: begin
				acc_next = tap_shr(taps_next[0], 8) +
					tap_shr(taps_next[1], 8) +
					tap_shr(taps_next[2], 7) +
					tap_shr(taps_next[3], 6) +
					tap_shr(taps_next[4], 5) +
					tap_shr(taps_next[5], 4) +
					tap_shr(taps_next[6], 3) +
					tap_shr(taps_next[7], 2) +
					tap_shr(taps_next[8], 2);
			end
			shape_c: begin
				// Peaks at tap 10 and holds 1/8 over the four oldest taps used.
				acc_next = tap_shr(taps_next[0], 11) +
					tap_shr(taps_next[1], 11) +
					tap_shr(taps_next[2], 10) +
					tap_shr(taps_next[3], 9) +
					tap_shr(taps_next[4], 8) +
					tap_shr(taps_next[5], 7) +
					tap_shr(taps_next[6], 6) +
					tap_shr(taps_next[7], 5) +
					tap_shr(taps_next[8], 4) +
					tap_shr(taps_next[9], 3) +
					tap_shr(taps_next[10], 2) +
					tap_shr(taps_next[11], 3) +
					tap_shr(taps_next[12], 3) +
					tap_shr(taps_next[13], 3) +
					tap_shr(taps_next[14], 3);
			end
			shape_d: begin
				// Tap 13 carries a quarter on top of its eighth, as two terms.
				acc_next = tap_shr(taps_next[0], 15) +
					tap_shr(taps_next[1], 15) +
					tap_shr(taps_next[2], 14) +
					tap_shr(taps_next[3], 13) +
					tap_shr(taps_next[4], 12) +
					tap_shr(taps_next[5], 11) +
					tap_shr(taps_next[6], 10) +
					tap_shr(taps_next[7], 9) +
					tap_shr(taps_next[8], 8) +
					tap_shr(taps_next[9], 7) +
					tap_shr(taps_next[10], 6) +
					tap_shr(taps_next[11], 5) +
					tap_shr(taps_next[12], 4) +
					tap_shr(taps_next[13], 3) +
					tap_shr(taps_next[14], 2) +
					tap_shr(taps_next[15], 2) +
					tap_shr(taps_next[13], 2);
			end
			default: begin
				acc_next = '0;
			end
		endcase
	end

	// Taps and accumulator move together, so acc always matches the taps.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			taps      <= '{default: '0};
			acc       <= '0;
			acc_valid <= 1'b0;
		end else begin
			acc_valid <= sample_en;
			if (sample_en) begin
				taps <= taps_next;
				acc  <= acc_next;
			end
		end
	end

	a_valid_after_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		acc_valid |-> $past(sample_en));

endmodule

`default_nettype wire

//--- hw/stereo_acc_if.sv
`default_nettype none

// Carries both channel accumulators from the filter banks to the limiter.
// The two banks run in lockstep, so one valid strobe covers both channels.
interface stereo_acc_if
	import audio_pkg::*;
#(
	parameter int BIT_WIDTH = sample_width
);

	logic signed [BIT_WIDTH+guard_bits-1:0] left_acc;
	logic signed [BIT_WIDTH+guard_bits-1:0] right_acc;
	logic                                   acc_valid;
	logic                                   mute;

	// Filter banks and the control block together.
	modport source (output left_acc, output right_acc, output acc_valid, output mute);

	// The limiter always accepts, so there is no return path.
	modport sink (input left_acc, input right_acc, input acc_valid, input mute);

endinterface

`default_nettype wire

//--- hw/filt_pkg.sv
`default_nettype none

// Filter selection and click suppression.
package filt_pkg;

	import audio_pkg::*;

	// One value per filter mode. The encoding matches the 3-bit selection
	// field, so software sees the same numbers.
	//
	// Modes 0 to 3 are plain running averages. Every tap in use carries the
	// same power-of-two weight.
	//   avg2   two taps at 1/2
	//   avg4   four taps at 1/4
	//   avg8   eight taps at 1/8
	//   avg16  sixteen taps at 1/16
	//
	// Modes 4 to 7 are weighted shapes. The weights halve from tap to tap
	// towards the newest sample and flatten out at the older end.
	//   shape_a  taps 0 to 7
	//   shape_b  taps 0 to 8
	//   shape_c  taps 0 to 14
	//   shape_d  all sixteen taps, with a second term on tap 13
	typedef enum logic [2:0] {
		avg2    = 3'd0,
		avg4    = 3'd1,
		avg8    = 3'd2,
		avg16   = 3'd3,
		shape_a = 3'd4,
		shape_b = 3'd5,
		shape_c = 3'd6,
		shape_d = 3'd7
	} filt_mode_e;

	// Number of sample strobes muted after a selection write.
	// One full delay line, so no output mixes samples from the old filter
	// into the new one.
	parameter int mute_samples = num_taps;

endpackage

`default_nettype wire

//--- hw/audio_pkg.sv
`default_nettype none

// Constants shared by the sample path.
// The sample width itself is a module parameter, and the value below is only
// the default that the top level hands down.
package audio_pkg;

	// Default width of a signed audio sample.
	parameter int sample_width = 24;

	// Depth of each channel's delay line.
	// Tap 0 holds the newest sample and tap num_taps-1 the oldest.
	parameter int num_taps = 16;

	// Extra accumulator bits above the sample width.
	// They give the shift-add sum headroom before the limiter clamps it,
	// including the downward step of floor truncation on negative taps.
	parameter int guard_bits = 4;

endpackage

`default_nettype wire
